// File: list.f
ddr_mem_pkg.sv
avmm_cmd_capture.sv
burst_sequencer.sv
bank_ram.sv
read_return.sv
ddr_mem_top.sv
ddr_mem_checker.sv
tb_ddr_mem.sv

// File: run.sh
#!/bin/sh
# build and run the ddr memory testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ddr_mem \
	-f list.f \
	-o sim_ddr_mem

# run from the project root so the data file is found
status=0
./obj_dir/sim_ddr_mem > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Something failed" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

// File: ddr_mem_input.txt
# bank op byte_addr(hex) count(dec) byteenable(hex) data(hex)
# op W write beat, R read command, E expected read word (count repeats the word)
0 W 010 1 ff 0123456789abcdef
1 W 010 1 ff fedcba9876543210
0 R 010 1 00 0
0 E 000 1 00 0123456789abcdef
1 R 017 1 00 0
1 E 000 1 00 fedcba9876543210
0 R 100 1 00 0
0 E 000 1 00 0
0 W 010 1 81 aaaaaaaaaaaaaaaa
0 R 010 1 00 0
0 E 000 1 00 aa23456789abcdaa
1 W 7f8 1 ff 5555aaaa5555aaaa
1 W 000 1 ff 0f0f0f0f0f0f0f0f
0 W 200 4 ff 00000000000000a0
0 W 200 4 ff 00000000000000a1
1 R 780 64 00 0
0 W 200 4 ff 00000000000000a2
0 W 200 4 ff 00000000000000a3
0 R 200 4 00 0
0 E 000 1 00 00000000000000a0
0 E 000 1 00 00000000000000a1
0 E 000 1 00 00000000000000a2
0 E 000 1 00 00000000000000a3
1 E 000 15 00 0
1 E 000 1 00 5555aaaa5555aaaa
1 E 000 1 00 0f0f0f0f0f0f0f0f
1 E 000 1 00 0
1 E 000 1 00 fedcba9876543210
1 E 000 45 00 0

// File: tb_ddr_mem.sv
`timescale 1ns/100ps

module tb_ddr_mem;
	import ddr_mem_pkg::*;

	logic                 DDR4_USERCLK = 1'b0;
	logic                 rst;
	avmm_cmd_t            cmd [NUM_BANKS];
	logic [NUM_BANKS-1:0] waitrequest;
	avmm_rsp_t            rsp [NUM_BANKS];

	int          st_bank [$];             // target bank per command
	avmm_cmd_t   st_cmd [$];              // W and R lines in file order
	int          file_lines    = 0;
	int          load_err      = 0;       // unreadable file or bad lines
	int          hs_err        = 0;       // waitrequest wrong after reset
	int          n_err;
	int unsigned lcg_state     = 32;      // seed
	int unsigned cycle_cnt     = 0;
	int unsigned timeout_limit = 0;       // set once the file is read

	always #50 DDR4_USERCLK = ~DDR4_USERCLK;   // 100 ns period

	ddr_mem_top i_dut (
		.DDR4_USERCLK (DDR4_USERCLK),
		.rst          (rst),
		.cmd          (cmd),
		.waitrequest  (waitrequest),
		.rsp          (rsp)
	);

	ddr_mem_checker i_chk (
		.DDR4_USERCLK (DDR4_USERCLK),
		.rst          (rst),
		.rsp          (rsp)
	);

	// ********************
	// helpers
	// ********************

	// 0..3 idle cycles from a plain lcg
	function automatic int unsigned draw_idle_gap();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % 4;
	endfunction

	task automatic load_stimulus();
		int fd;
		string line;
		int bank;
		byte op;
		logic [31:0] addr;
		int cnt;
		logic [DATA_BYTES-1:0] be;
		logic [DATA_WIDTH-1:0] data;
		avmm_cmd_t c;
		fd = $fopen("ddr_mem_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open ddr_mem_input.txt");
			load_err++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			file_lines++;
			if (line.len() < 2 || line.getc(0) == 8'h23)
				continue;   // blank or comment
			if ($sscanf(line, "%d %c %h %d %h %h", bank, op, addr, cnt, be, data) != 6
				|| bank < 0 || bank >= NUM_BANKS) begin
				$display("line %0d of ddr_mem_input.txt cannot be parsed", file_lines);
				load_err++;
			end else if (op == "E") begin
				repeat (cnt) i_chk.push_expected(bank, data);
			end else begin
				c            = '0;
				c.read       = (op == "R");
				c.write      = (op == "W");
				c.address    = addr[BYTE_ADDR_WIDTH-1:0];
				c.burstcount = cnt[BURST_WIDTH-1:0];
				c.byteenable = be;
				c.writedata  = data;
				st_bank.push_back(bank);
				st_cmd.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// present one beat, keep it until an edge with waitrequest low
	task automatic send_beat(input int bank, input avmm_cmd_t c);
		logic stall;
		cmd[bank] <= c;
		stall = 1'b1;
		while (stall) begin
			@(negedge DDR4_USERCLK);
			stall = waitrequest[bank];   // value seen at the coming edge
			@(posedge DDR4_USERCLK);
		end
		cmd[bank] <= '0;
	endtask

	// ********************
	// main sequence
	// ********************
	initial begin
		for (int b = 0; b < NUM_BANKS; b++)
			cmd[b] = '0;
		rst = 1'b1;
		load_stimulus();
		timeout_limit = 20 * file_lines + 200;
		repeat (8) @(posedge DDR4_USERCLK);
		rst <= 1'b0;
		@(negedge DDR4_USERCLK);
		if (waitrequest !== '0) begin   // idle banks never stall
			hs_err++;
			$display("ERR %0t waitrequest expected %b actual %b",
				$time, {NUM_BANKS{1'b0}}, waitrequest);
		end
		@(posedge DDR4_USERCLK);
		for (int i = 0; i < st_cmd.size(); i++) begin
			repeat (draw_idle_gap()) @(posedge DDR4_USERCLK);
			send_beat(st_bank[i], st_cmd[i]);
		end
		while (i_chk.pending_words() != 0)
			@(posedge DDR4_USERCLK);
		repeat (8) @(posedge DDR4_USERCLK);   // room for stray responses
		i_chk.final_report(n_err);
		if (n_err == 0 && load_err == 0 && hs_err == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog
	always @(posedge DDR4_USERCLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (timeout_limit != 0 && cycle_cnt == timeout_limit) begin
			$display("run did not finish within %0d cycles", timeout_limit);
			i_chk.final_report(n_err);
			$display("Something failed");
			$finish;
		end
	end

endmodule

// File: ddr_mem_checker.sv
`timescale 1ns/100ps

module ddr_mem_checker (
	input  logic                   DDR4_USERCLK,
	input  logic                   rst,
	input  ddr_mem_pkg::avmm_rsp_t rsp [ddr_mem_pkg::NUM_BANKS]
);
	import ddr_mem_pkg::*;

	logic [DATA_WIDTH-1:0] exp_q [NUM_BANKS][$];   // expected words, oldest first
	logic [DATA_WIDTH-1:0] want;
	int                    checked    = 0;
	int                    mismatches = 0;
	int                    unexpected = 0;         // responses nobody asked for
	int                    missing    = 0;         // words never returned

	// ********************
	// expected queue access
	// ********************
	task automatic push_expected(input int bank, input logic [DATA_WIDTH-1:0] word);
		exp_q[bank].push_back(word);
	endtask

	function automatic int pending_words();
		int n;
		n = 0;
		for (int b = 0; b < NUM_BANKS; b++)
			n += exp_q[b].size();
		return n;
	endfunction

	// ********************
	// response compare
	// ********************

	// mid cycle, registered rsp is settled here
	always @(negedge DDR4_USERCLK) begin
		if (!rst) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				if ($isunknown(rsp[b].readdatavalid)) begin
					unexpected++;
					$display("%0t: bank %0d readdatavalid is unknown", $time, b);
				end else if (rsp[b].readdatavalid) begin
					if (exp_q[b].size() == 0) begin
						unexpected++;   // no read outstanding
						$display("%0t: bank %0d returned a word that no read asked for",
							$time, b);
					end else begin
						want = exp_q[b].pop_front();
						checked++;
						if (rsp[b].readdata !== want) begin
							mismatches++;
							$display("ERR %0t rsp[%0d].readdata expected %h actual %h",
								$time, b, want, rsp[b].readdata);
						end
					end
				end
			end
		end
	end

	// leftovers count as lost reads
	task automatic final_report(output int errors);
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (exp_q[b].size() != 0) begin
				$display("bank %0d never returned %0d expected read words", b, exp_q[b].size());
				missing += exp_q[b].size();
				exp_q[b].delete();
			end
		end
		errors = mismatches + unexpected + missing;
		$display("checked %0d words, %0d mismatches, %0d unexpected, %0d missing",
			checked, mismatches, unexpected, missing);
	endtask

endmodule

// File: ddr_mem_top.sv
`timescale 1ns/100ps

module ddr_mem_top (
	input  logic                               DDR4_USERCLK,
	input  logic                               rst,
	input  ddr_mem_pkg::avmm_cmd_t             cmd [ddr_mem_pkg::NUM_BANKS],
	output logic [ddr_mem_pkg::NUM_BANKS-1:0]  waitrequest,
	output ddr_mem_pkg::avmm_rsp_t             rsp [ddr_mem_pkg::NUM_BANKS]
);
	import ddr_mem_pkg::*;

	// ********************
	// one chain per bank
	// ********************
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		mem_beat_t                  beat;
		logic                       beat_valid;
		logic                       beat_take;
		logic                       ram_rd;
		logic                       ram_wr;
		logic                       rd_issue;
		logic [WORD_ADDR_WIDTH-1:0] ram_addr;
		logic [DATA_WIDTH-1:0]      ram_wdata;
		logic [DATA_WIDTH-1:0]      ram_mask;
		logic [DATA_WIDTH-1:0]      ram_rdata;

		// input side
		avmm_cmd_capture i_capture (
			.DDR4_USERCLK (DDR4_USERCLK),
			.rst          (rst),
			.cmd          (cmd[b]),
			.beat_take    (beat_take),
			.waitrequest  (waitrequest[b]),
			.beat         (beat),
			.beat_valid   (beat_valid)
		);

		burst_sequencer i_seq (
			.DDR4_USERCLK (DDR4_USERCLK),
			.rst          (rst),
			.beat         (beat),
			.beat_valid   (beat_valid),
			.beat_take    (beat_take),
			.ram_rd       (ram_rd),
			.ram_wr       (ram_wr),
			.ram_addr     (ram_addr),
			.ram_wdata    (ram_wdata),
			.ram_mask     (ram_mask),
			.rd_issue     (rd_issue)
		);

		bank_ram i_ram (
			.DDR4_USERCLK (DDR4_USERCLK),
			.ram_rd       (ram_rd),
			.ram_wr       (ram_wr),
			.ram_addr     (ram_addr),
			.ram_wdata    (ram_wdata),
			.ram_mask     (ram_mask),
			.ram_rdata    (ram_rdata)
		);

		// output side
		read_return i_ret (
			.DDR4_USERCLK (DDR4_USERCLK),
			.rst          (rst),
			.ram_wr       (ram_wr),
			.ram_addr     (ram_addr),
			.rd_issue     (rd_issue),
			.ram_rdata    (ram_rdata),
			.rsp          (rsp[b])
		);
	end

endmodule

// File: read_return.sv
`timescale 1ns/100ps

module read_return (
	input  logic                                    DDR4_USERCLK,
	input  logic                                    rst,
	input  logic                                    ram_wr,
	input  logic [ddr_mem_pkg::WORD_ADDR_WIDTH-1:0] ram_addr,
	input  logic                                    rd_issue,
	input  logic [ddr_mem_pkg::DATA_WIDTH-1:0]      ram_rdata,
	output ddr_mem_pkg::avmm_rsp_t                  rsp
);
	import ddr_mem_pkg::*;

	logic [MEM_WORDS-1:0] written;      // one bit per word ever written
	logic                 v1;           // ram read in flight
	logic                 w1;           // its word was written

	// ********************
	// written bitmap
	// ********************
	always_ff @(posedge DDR4_USERCLK) begin
		if (rst) begin
			written <= '0;
		end else if (ram_wr) begin
			written[ram_addr] <= 1'b1;
		end
	end

	// stage 1, lines up with the ram read
	always_ff @(posedge DDR4_USERCLK) begin
		if (rst) begin
			v1 <= 1'b0;
			w1 <= 1'b0;
		end else begin
			v1 <= rd_issue;
			w1 <= written[ram_addr];   // ram_wr low here, no bypass needed
		end
	end

	// ********************
	// response register
	// ********************
	always_ff @(posedge DDR4_USERCLK) begin
		if (rst)
			rsp.readdatavalid <= 1'b0;
		else
			rsp.readdatavalid <= v1;
	end

	always_ff @(posedge DDR4_USERCLK) begin
		if (v1)
			rsp.readdata <= w1 ? ram_rdata : '0;   // zero fill for fresh words
	end

	a_rdv_known: assert property (
		@(posedge DDR4_USERCLK) disable iff (rst)
		!$isunknown(rsp.readdatavalid)
	);

endmodule

// File: bank_ram.sv
`timescale 1ns/100ps

module bank_ram (
	input  logic                                    DDR4_USERCLK,
	input  logic                                    ram_rd,
	input  logic                                    ram_wr,
	input  logic [ddr_mem_pkg::WORD_ADDR_WIDTH-1:0] ram_addr,
	input  logic [ddr_mem_pkg::DATA_WIDTH-1:0]      ram_wdata,
	input  logic [ddr_mem_pkg::DATA_WIDTH-1:0]      ram_mask,
	output logic [ddr_mem_pkg::DATA_WIDTH-1:0]      ram_rdata
);
	import ddr_mem_pkg::*;

	// ********************
	// storage
	// ********************
	logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

	// block ram powers up cleared, partial writes merge into zero
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// masked write, untouched bits keep old word
	always_ff @(posedge DDR4_USERCLK) begin
		if (ram_wr) begin
			mem[ram_addr] <= (mem[ram_addr] & ~ram_mask) | (ram_wdata & ram_mask);
		end
	end

	// registered read, one cycle
	always_ff @(posedge DDR4_USERCLK) begin
		if (ram_rd) begin
			ram_rdata <= mem[ram_addr];
		end
	end

endmodule

// File: burst_sequencer.sv
`timescale 1ns/100ps

module burst_sequencer (
	input  logic                                     DDR4_USERCLK,
	input  logic                                     rst,
	input  ddr_mem_pkg::mem_beat_t                   beat,
	input  logic                                     beat_valid,
	output logic                                     beat_take,
	output logic                                     ram_rd,
	output logic                                     ram_wr,
	output logic [ddr_mem_pkg::WORD_ADDR_WIDTH-1:0]  ram_addr,
	output logic [ddr_mem_pkg::DATA_WIDTH-1:0]       ram_wdata,
	output logic [ddr_mem_pkg::DATA_WIDTH-1:0]       ram_mask,
	output logic                                     rd_issue   // tags word sent to ram
);
	import ddr_mem_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_RD,       // read burst, command still held upstream
		S_WR        // write burst open, waiting for further beats
	} state_t;

	state_t                     state;
	logic [WORD_ADDR_WIDTH-1:0] addr_cnt;     // next word of the burst
	logic [BURST_WIDTH-1:0]     left;         // words still due after the last issue
	logic                       issue_rd;
	logic                       issue_wr;
	logic                       last;         // word issued now closes the burst
	logic [WORD_ADDR_WIDTH-1:0] issue_addr;

	// ********************
	// issue decision
	// ********************
	always_comb begin
		issue_rd   = 1'b0;
		issue_wr   = 1'b0;
		last       = 1'b0;
		issue_addr = addr_cnt;
		case (state)
			S_IDLE: begin
				if (beat_valid) begin
					issue_addr = beat.addr;           // first word from the beat itself
					issue_rd   = beat.read;
					issue_wr   = beat.write;
					last       = (beat.burstcount == BURST_WIDTH'(1));
				end
			end
			S_RD: begin
				issue_rd = beat_valid;                // read cmd stays held
				last     = (left == BURST_WIDTH'(1));
			end
			S_WR: begin
				issue_wr = beat_valid & beat.write;   // one word per write beat
				last     = (left == BURST_WIDTH'(1));
			end
			default: ;
		endcase
	end

	// writes taken at once, reads only on their final word
	assign beat_take = issue_wr | (issue_rd & last);

	// ********************
	// burst state
	// ********************
	always_ff @(posedge DDR4_USERCLK) begin
		if (rst) begin
			state    <= S_IDLE;
			addr_cnt <= '0;
			left     <= '0;
			ram_rd   <= 1'b0;
			ram_wr   <= 1'b0;
			rd_issue <= 1'b0;
		end else begin
			ram_rd   <= issue_rd;
			ram_wr   <= issue_wr;
			rd_issue <= issue_rd;
			if (issue_rd || issue_wr) begin
				addr_cnt <= issue_addr + 1'b1;       // wraps at MEM_WORDS
				if (state == S_IDLE) begin
					left <= beat.burstcount - 1'b1;  // counters loaded from first beat
					if (!last)
						state <= issue_rd ? S_RD : S_WR;
				end else begin
					left <= left - 1'b1;
					if (last)
						state <= S_IDLE;
				end
			end
		end
	end

	// ram payload
	always_ff @(posedge DDR4_USERCLK) begin
		ram_addr  <= issue_addr;
		ram_wdata <= beat.wdata;
		ram_mask  <= beat.mask;   // per beat enables, not latched from first beat
	end

	// a beat flagged both read and write would drive both ports
	a_rd_wr_excl: assert property (
		@(posedge DDR4_USERCLK) disable iff (rst)
		!(ram_rd && ram_wr)
	);

	// master must finish a write burst before reading
	a_no_rd_in_wr: assert property (
		@(posedge DDR4_USERCLK) disable iff (rst)
		(state == S_WR) |-> !(beat_valid && beat.read)
	);

endmodule

// File: avmm_cmd_capture.sv
`timescale 1ns/100ps

module avmm_cmd_capture (
	input  logic                   DDR4_USERCLK,
	input  logic                   rst,
	input  ddr_mem_pkg::avmm_cmd_t cmd,
	input  logic                   beat_take,     // sequencer consumes held beat
	output logic                   waitrequest,
	output ddr_mem_pkg::mem_beat_t beat,
	output logic                   beat_valid
);
	import ddr_mem_pkg::*;

	logic                   accept;               // beat accepted at next edge
	logic                   burst_start;          // accepted beat opens a burst
	logic [BURST_WIDTH-1:0] wr_left;              // write beats still due in burst
	logic [DATA_WIDTH-1:0]  bit_mask;

	// ********************
	// handshake
	// ********************

	// stall only while a held beat is not consumed this cycle
	assign waitrequest = beat_valid & ~beat_take;
	assign accept      = (cmd.read | cmd.write) & ~waitrequest;
	assign burst_start = cmd.read | (wr_left == '0);  // reads are always single cmd

	// widen byte enables, each one covers a full byte lane
	always_comb begin
		for (int i = 0; i < DATA_BYTES; i++) begin
			bit_mask[i*8 +: 8] = {8{cmd.byteenable[i]}};
		end
	end

	// ********************
	// holding register
	// ********************
	always_ff @(posedge DDR4_USERCLK) begin
		if (rst) begin
			beat_valid <= 1'b0;
			wr_left    <= '0;
		end else begin
			if (accept)
				beat_valid <= 1'b1;       // new beat replaces a taken one
			else if (beat_take)
				beat_valid <= 1'b0;

			// follow write bursts so burst starts can be told apart
			if (accept && cmd.write) begin
				if (wr_left == '0)
					wr_left <= cmd.burstcount - 1'b1;
				else
					wr_left <= wr_left - 1'b1;
			end
		end
	end

	// payload, no reset needed
	always_ff @(posedge DDR4_USERCLK) begin
		if (accept) begin
			beat.read       <= cmd.read;
			beat.write      <= cmd.write;
			beat.addr       <= cmd.address[BYTE_ADDR_WIDTH-1 -: WORD_ADDR_WIDTH]; // drop lsbs
			beat.burstcount <= cmd.burstcount;
			beat.wdata      <= cmd.writedata;
			beat.mask       <= bit_mask;
		end
	end

	// a burst may never be opened with a zero length
	a_burst_len: assert property (
		@(posedge DDR4_USERCLK) disable iff (rst)
		(accept && burst_start) |-> (cmd.burstcount != '0)
	);

endmodule

// File: ddr_mem_pkg.sv
package ddr_mem_pkg;

	// ********************
	// sizes
	// ********************
	localparam int DATA_BYTES      = 8;                 // bytes per word
	localparam int DATA_WIDTH      = DATA_BYTES * 8;    // 64 bit data path
	localparam int MEM_WORDS       = 256;               // words per bank
	localparam int WORD_ADDR_WIDTH = 8;                 // log2 of MEM_WORDS
	localparam int BYTE_ADDR_WIDTH = 11;                // low 3 bits unused
	localparam int BURST_WIDTH     = 7;                 // burstcount 1..64
	localparam int NUM_BANKS       = 2;

	// ********************
	// bus side types
	// ********************

	// one avalon-mm command beat as driven by the master
	typedef struct packed {
		logic                       read;
		logic                       write;
		logic [BYTE_ADDR_WIDTH-1:0] address;     // byte address
		logic [BURST_WIDTH-1:0]     burstcount;
		logic [DATA_WIDTH-1:0]      writedata;
		logic [DATA_BYTES-1:0]      byteenable;
	} avmm_cmd_t;

	// captured beat, word addressed, enables already widened
	typedef struct packed {
		logic                       read;
		logic                       write;
		logic [WORD_ADDR_WIDTH-1:0] addr;
		logic [BURST_WIDTH-1:0]     burstcount;
		logic [DATA_WIDTH-1:0]      wdata;
		logic [DATA_WIDTH-1:0]      mask;        // one bit per data bit
	} mem_beat_t;

	typedef struct packed {
		logic                  readdatavalid;
		logic [DATA_WIDTH-1:0] readdata;
	} avmm_rsp_t;

endpackage
